// File: decode_pkg.sv
`default_nettype none

package decode_pkg;

	// ------------------------------
	// widths and fixed values
	// ------------------------------

	localparam int unsigned W_ADDR    = 32;
	localparam int unsigned W_DATA    = 32;
	localparam int unsigned W_REGADDR = 5;

	localparam logic [W_ADDR-1:0] RESET_VECTOR = 32'h0000_0040;

	// only 32-bit instructions exist here, so the PC always steps by a word
	localparam logic [W_ADDR-1:0] INSTR_BYTES = 32'd4;

	localparam logic [W_REGADDR-1:0] REG_ZERO = '0;

	// ------------------------------
	// encodings
	// ------------------------------

	// major opcode, taken from instruction bits 6:2
	typedef enum logic [4:0] {
		OPC_LOAD     = 5'b00000,
		OPC_MISC_MEM = 5'b00011,
		OPC_OP_IMM   = 5'b00100,
		OPC_AUIPC    = 5'b00101,
		OPC_STORE    = 5'b01000,
		OPC_OP       = 5'b01100,
		OPC_LUI      = 5'b01101,
		OPC_BRANCH   = 5'b11000,
		OPC_JALR     = 5'b11001,
		OPC_JAL      = 5'b11011
	} opcode_e;

	typedef enum logic [3:0] {
		ALUOP_ADD,
		ALUOP_SUB,
		ALUOP_SLL,
		ALUOP_LT,
		ALUOP_LTU,
		ALUOP_XOR,
		ALUOP_SRL,
		ALUOP_SRA,
		ALUOP_OR,
		ALUOP_AND,
		ALUOP_RS2
	} aluop_e;

	typedef enum logic {ALUSRCA_RS1, ALUSRCA_PC} alusrc_a_e;
	typedef enum logic {ALUSRCB_RS2, ALUSRCB_IMM} alusrc_b_e;

	typedef enum logic [3:0] {
		MEMOP_NONE,
		MEMOP_LB,
		MEMOP_LH,
		MEMOP_LW,
		MEMOP_LBU,
		MEMOP_LHU,
		MEMOP_SB,
		MEMOP_SH,
		MEMOP_SW
	} memop_e;

	// branch is taken when the ALU result matches the condition
	typedef enum logic [1:0] {BCOND_NEVER, BCOND_ZERO, BCOND_NZERO, BCOND_ALWAYS} bcond_e;

	typedef enum logic [1:0] {EXCEPT_NONE, EXCEPT_INSTR_ILLEGAL, EXCEPT_INSTR_FAULT} except_e;

	typedef enum logic {LOCK_IDLE, LOCK_HELD} lock_state_e;

	// ------------------------------
	// bundles
	// ------------------------------

	// vld counts valid halfwords from the bottom, err flags a bus error per halfword
	typedef struct packed {
		logic [W_DATA-1:0] cir;
		logic [1:0]        vld;
		logic [1:0]        err;
	} fetch_t;

	typedef struct packed {
		logic [W_REGADDR-1:0] rs1;
		logic [W_REGADDR-1:0] rs2;
		logic [W_REGADDR-1:0] rd;
		logic [W_DATA-1:0]    imm;
		alusrc_a_e            alusrc_a;
		alusrc_b_e            alusrc_b;
		aluop_e               aluop;
		memop_e               memop;
		bcond_e               branchcond;
		logic [W_ADDR-1:0]    addr_offs;
		logic                 addr_is_regoffs;
		except_e              except;
	} d_ctrl_t;

endpackage

`default_nettype wire

// File: instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder
	import decode_pkg::*;
(
	input  wire [W_DATA-1:0] cir_i,
	output d_ctrl_t          raw_ctrl_o,
	output logic             illegal_o
);

	opcode_e           opcode;
	logic [2:0]        funct3;
	logic [6:0]        funct7;
	logic [W_DATA-1:0] imm_i;
	logic [W_DATA-1:0] imm_s;
	logic [W_DATA-1:0] imm_b;
	logic [W_DATA-1:0] imm_u;
	logic [W_DATA-1:0] imm_j;
	logic [W_ADDR-1:0] addr_offs;
	d_ctrl_t           raw;

	assign opcode = opcode_e'(cir_i[6:2]);
	assign funct3 = cir_i[14:12];
	assign funct7 = cir_i[31:25];

	// ------------------------------
	// immediate formats
	// ------------------------------

	assign imm_i = {{21{cir_i[31]}}, cir_i[30:20]};
	assign imm_s = {{21{cir_i[31]}}, cir_i[30:25], cir_i[11:7]};
	assign imm_b = {{20{cir_i[31]}}, cir_i[7], cir_i[30:25], cir_i[11:8], 1'b0};
	assign imm_u = {cir_i[31:12], 12'h000};
	assign imm_j = {{12{cir_i[31]}}, cir_i[19:12], cir_i[20], cir_i[30:21], 1'b0};

	// the offset added to the address base in execute, per format
	always_comb begin
		case (opcode)
			OPC_JAL:    addr_offs = imm_j;
			OPC_BRANCH: addr_offs = imm_b;
			OPC_STORE:  addr_offs = imm_s;
			OPC_JALR:   addr_offs = imm_i;
			OPC_LOAD:   addr_offs = imm_i;
			default:    addr_offs = '0;
		endcase
	end

	// alt selects SUB over ADD and SRA over SRL
	function automatic aluop_e alu_from_funct3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  alu_from_funct3 = alt ? ALUOP_SUB : ALUOP_ADD;
			3'b001:  alu_from_funct3 = ALUOP_SLL;
			3'b010:  alu_from_funct3 = ALUOP_LT;
			3'b011:  alu_from_funct3 = ALUOP_LTU;
			3'b100:  alu_from_funct3 = ALUOP_XOR;
			3'b101:  alu_from_funct3 = alt ? ALUOP_SRA : ALUOP_SRL;
			3'b110:  alu_from_funct3 = ALUOP_OR;
			default: alu_from_funct3 = ALUOP_AND;
		endcase
	endfunction

	// ------------------------------
	// control decode
	// ------------------------------

	always_comb begin
		raw.rs1             = cir_i[19:15];
		raw.rs2             = cir_i[24:20];
		raw.rd              = cir_i[11:7];
		raw.imm             = imm_i;
		raw.alusrc_a        = ALUSRCA_RS1;
		raw.alusrc_b        = ALUSRCB_RS2;
		raw.aluop           = ALUOP_ADD;
		raw.memop           = MEMOP_NONE;
		raw.branchcond      = BCOND_NEVER;
		raw.addr_offs       = addr_offs;
		raw.addr_is_regoffs = 1'b0;
		raw.except          = EXCEPT_NONE;
		illegal_o           = 1'b0;

		case (opcode)
			OPC_LOAD: begin
				raw.rs2             = REG_ZERO;
				raw.addr_is_regoffs = 1'b1;
				case (funct3)
					3'b000:  raw.memop = MEMOP_LB;
					3'b001:  raw.memop = MEMOP_LH;
					3'b010:  raw.memop = MEMOP_LW;
					3'b100:  raw.memop = MEMOP_LBU;
					3'b101:  raw.memop = MEMOP_LHU;
					default: illegal_o = 1'b1;
				endcase
			end
			OPC_STORE: begin
				// store data passes through the ALU from rs2
				raw.rd              = REG_ZERO;
				raw.aluop           = ALUOP_RS2;
				raw.addr_is_regoffs = 1'b1;
				case (funct3)
					3'b000:  raw.memop = MEMOP_SB;
					3'b001:  raw.memop = MEMOP_SH;
					3'b010:  raw.memop = MEMOP_SW;
					default: illegal_o = 1'b1;
				endcase
			end
			OPC_BRANCH: begin
				raw.rd = REG_ZERO;
				// funct3[2] picks a compare over equality, funct3[1] makes it unsigned
				raw.aluop = !funct3[2] ? ALUOP_SUB : (funct3[1] ? ALUOP_LTU : ALUOP_LT);
				// the sense inverts when exactly one of funct3[2] and funct3[0] is set
				raw.branchcond = (funct3[2] ^ funct3[0]) ? BCOND_NZERO : BCOND_ZERO;
				illegal_o      = funct3[2:1] == 2'b01;
			end
			OPC_JALR: begin
				// the ALU forms the link address while the adder forms the target
				raw.rs2             = REG_ZERO;
				raw.imm             = INSTR_BYTES;
				raw.alusrc_a        = ALUSRCA_PC;
				raw.alusrc_b        = ALUSRCB_IMM;
				raw.branchcond      = BCOND_ALWAYS;
				raw.addr_is_regoffs = 1'b1;
				illegal_o           = funct3 != 3'b000;
			end
			OPC_JAL: begin
				raw.rs1        = REG_ZERO;
				raw.rs2        = REG_ZERO;
				raw.imm        = INSTR_BYTES;
				raw.alusrc_a   = ALUSRCA_PC;
				raw.alusrc_b   = ALUSRCB_IMM;
				raw.branchcond = BCOND_ALWAYS;
			end
			OPC_OP_IMM: begin
				raw.rs2      = REG_ZERO;
				raw.alusrc_b = ALUSRCB_IMM;
				raw.aluop    = alu_from_funct3(funct3, funct3 == 3'b101 && cir_i[30]);
				// shift amounts use only imm[4:0], the bits above act as funct7
				if (funct3 == 3'b001) begin
					illegal_o = funct7 != 7'b0000000;
				end else if (funct3 == 3'b101) begin
					illegal_o = funct7 != 7'b0000000 && funct7 != 7'b0100000;
				end
			end
			OPC_OP: begin
				raw.aluop = alu_from_funct3(funct3, cir_i[30]);
				if (funct7 == 7'b0100000) begin
					illegal_o = funct3 != 3'b000 && funct3 != 3'b101;
				end else begin
					illegal_o = funct7 != 7'b0000000;
				end
			end
			OPC_LUI: begin
				raw.rs1      = REG_ZERO;
				raw.rs2      = REG_ZERO;
				raw.imm      = imm_u;
				raw.alusrc_b = ALUSRCB_IMM;
				raw.aluop    = ALUOP_RS2;
			end
			OPC_AUIPC: begin
				raw.rs1      = REG_ZERO;
				raw.rs2      = REG_ZERO;
				raw.imm      = imm_u;
				raw.alusrc_a = ALUSRCA_PC;
				raw.alusrc_b = ALUSRCB_IMM;
			end
			OPC_MISC_MEM: begin
				// FENCE has nothing to order in this core and retires as a no-op
				raw.rs1   = REG_ZERO;
				raw.rs2   = REG_ZERO;
				raw.rd    = REG_ZERO;
				illegal_o = funct3 != 3'b000;
			end
			default: begin
				illegal_o = 1'b1;
			end
		endcase

		// no compressed support, so anything without 11 in the low bits is rejected
		if (cir_i[1:0] != 2'b11) begin
			illegal_o = 1'b1;
		end
	end

	assign raw_ctrl_o = raw;

endmodule

`default_nettype wire

// File: decode_gate.sv
`timescale 1ns/1ns
`default_nettype none

module decode_gate
	import decode_pkg::*;
(
	input  wire d_ctrl_t raw_ctrl_i,
	input  wire          illegal_i,
	input  wire          starved_i,
	input  wire          bus_fault_i,
	input  wire          lock_held_i,
	output d_ctrl_t      ctrl_o
);

	always_comb begin
		ctrl_o = raw_ctrl_i;

		// anything that cannot issue becomes a bubble with no side effects
		if (illegal_i || starved_i || bus_fault_i) begin
			ctrl_o.rs1             = REG_ZERO;
			ctrl_o.rs2             = REG_ZERO;
			ctrl_o.rd              = REG_ZERO;
			ctrl_o.memop           = MEMOP_NONE;
			ctrl_o.branchcond      = BCOND_NEVER;
			ctrl_o.addr_is_regoffs = 1'b1;
			ctrl_o.aluop           = ALUOP_ADD;

			// a fetch error wins, since the bits it came with are not trustworthy
			if (bus_fault_i) begin
				ctrl_o.except = EXCEPT_INSTR_FAULT;
			end else if (illegal_i && !starved_i) begin
				ctrl_o.except = EXCEPT_INSTR_ILLEGAL;
			end else begin
				ctrl_o.except = EXCEPT_NONE;
			end
		end

		// the locked jump has already redirected fetch once
		if (lock_held_i) begin
			ctrl_o.branchcond = BCOND_NEVER;
		end
	end

endmodule

`default_nettype wire

// File: cir_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cir_ctrl
	import decode_pkg::*;
(
	input  wire       clk,
	input  wire       rst_n,
	input  wire [1:0] fetch_vld_i,
	input  wire [1:0] fetch_err_i,
	input  wire       x_stall_i,
	input  wire       jump_now_i,
	input  wire       jump_not_except_i,
	output logic      starved_o,
	output logic      stall_o,
	output logic      bus_fault_o,
	output logic [1:0] cir_use_o,
	output logic      flush_behind_o,
	output logic      lock_assert_o,
	output logic      lock_release_o,
	output logic      lock_active_o,
	output logic      lock_held_o
);

	lock_state_e lock_state;
	lock_state_e lock_state_next;

	// ------------------------------
	// consume and fault
	// ------------------------------

	assign starved_o = fetch_vld_i < 2'd2;
	assign stall_o   = x_stall_i || starved_o;
	assign cir_use_o = stall_o ? 2'd0 : 2'd2;

	// an error only counts on a halfword that fetch actually delivered
	assign bus_fault_o = (fetch_vld_i >= 2'd1 && fetch_err_i[0]) ||
		(fetch_vld_i == 2'd2 && fetch_err_i[1]);

	// ------------------------------
	// stalled jump lock
	// ------------------------------

	// a jump from the instruction in decode while stalled cannot be held back,
	// so fetch keeps this instruction and refills behind it until the stall clears
	assign lock_held_o    = lock_state == LOCK_HELD;
	assign lock_assert_o  = jump_now_i && jump_not_except_i && stall_o;
	assign lock_active_o  = (lock_held_o && stall_o) || lock_assert_o;
	assign lock_release_o = lock_held_o && !stall_o;
	assign flush_behind_o = lock_assert_o && !lock_held_o;

	assign lock_state_next = lock_active_o ? LOCK_HELD : LOCK_IDLE;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lock_state <= LOCK_IDLE;
		end else begin
			lock_state <= lock_state_next;
		end
	end

endmodule

`default_nettype wire

// File: pc_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pc_reg
	import decode_pkg::*;
(
	input  wire              clk,
	input  wire              rst_n,
	input  wire              jump_now_i,
	input  wire [W_ADDR-1:0] jump_target_i,
	input  wire              lock_assert_i,
	input  wire              lock_release_i,
	input  wire              lock_active_i,
	input  wire              stall_i,
	output logic [W_ADDR-1:0] pc_o
);

	logic [W_ADDR-1:0] pc_seq_next;

	assign pc_seq_next = pc_o + INSTR_BYTES;

	// a locked jump keeps the old PC for its link value and takes the target on release
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_o <= RESET_VECTOR;
		end else if ((jump_now_i && !lock_assert_i) || lock_release_i) begin
			pc_o <= jump_target_i;
		end else if (!stall_i && !lock_active_i) begin
			pc_o <= pc_seq_next;
		end
	end

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage
	import decode_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n,
	input  wire fetch_t       fetch_i,
	input  wire               x_stall_i,
	input  wire               jump_now_i,
	input  wire [W_ADDR-1:0]  jump_target_i,
	input  wire               jump_not_except_i,
	output logic [1:0]        cir_use_o,
	output logic              flush_behind_o,
	output logic [W_ADDR-1:0] pc_o,
	output d_ctrl_t           ctrl_o
);

	logic    starved;
	logic    stall;
	logic    bus_fault;
	logic    lock_assert;
	logic    lock_release;
	logic    lock_active;
	logic    lock_held;
	d_ctrl_t raw_ctrl;
	logic    illegal;

	// ------------------------------
	// instruction path
	// ------------------------------

	instr_decoder i_instr_decoder (
		.cir_i      (fetch_i.cir),
		.raw_ctrl_o (raw_ctrl),
		.illegal_o  (illegal)
	);

	decode_gate i_decode_gate (
		.raw_ctrl_i  (raw_ctrl),
		.illegal_i   (illegal),
		.starved_i   (starved),
		.bus_fault_i (bus_fault),
		.lock_held_i (lock_held),
		.ctrl_o      (ctrl_o)
	);

	// ------------------------------
	// flow control and PC
	// ------------------------------

	cir_ctrl i_cir_ctrl (
		.clk               (clk),
		.rst_n             (rst_n),
		.fetch_vld_i       (fetch_i.vld),
		.fetch_err_i       (fetch_i.err),
		.x_stall_i         (x_stall_i),
		.jump_now_i        (jump_now_i),
		.jump_not_except_i (jump_not_except_i),
		.starved_o         (starved),
		.stall_o           (stall),
		.bus_fault_o       (bus_fault),
		.cir_use_o         (cir_use_o),
		.flush_behind_o    (flush_behind_o),
		.lock_assert_o     (lock_assert),
		.lock_release_o    (lock_release),
		.lock_active_o     (lock_active),
		.lock_held_o       (lock_held)
	);

	pc_reg i_pc_reg (
		.clk            (clk),
		.rst_n          (rst_n),
		.jump_now_i     (jump_now_i),
		.jump_target_i  (jump_target_i),
		.lock_assert_i  (lock_assert),
		.lock_release_i (lock_release),
		.lock_active_i  (lock_active),
		.stall_i        (stall),
		.pc_o           (pc_o)
	);

endmodule

`default_nettype wire

// File: decode_stage_chk.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage_chk
	import decode_pkg::*;
(
	input wire              clk,
	input wire              rst_n,
	input wire fetch_t      fetch_i,
	input wire              x_stall_i,
	input wire              jump_now_i,
	input wire [1:0]        cir_use_o,
	input wire              flush_behind_o,
	input wire [W_ADDR-1:0] pc_o,
	input wire d_ctrl_t     ctrl_o
);

	// ------------------------------
	// stage invariants
	// ------------------------------

	// a jump only needs the lock while the instruction cannot leave decode
	assert property (@(posedge clk) disable iff (!rst_n)
		flush_behind_o |-> (x_stall_i || fetch_i.vld < 2'd2))
		else $error("flush_behind_o raised while decode was free to advance");

	assert property (@(posedge clk) disable iff (!rst_n)
		cir_use_o == 2'd0 || cir_use_o == 2'd2)
		else $error("cir_use_o holds a count other than 0 or 2");

	// an exception must never redirect the front end by itself
	assert property (@(posedge clk) disable iff (!rst_n)
		ctrl_o.except != EXCEPT_NONE |-> ctrl_o.branchcond == BCOND_NEVER)
		else $error("exception bubble carries a live branch condition");

	assert property (@(posedge clk) disable iff (!rst_n)
		(!jump_now_i && pc_o[1:0] == 2'b00) |=> pc_o[1:0] == 2'b00)
		else $error("pc_o lost word alignment without a jump");

endmodule

bind decode_stage decode_stage_chk i_decode_stage_chk (
	.clk            (clk),
	.rst_n          (rst_n),
	.fetch_i        (fetch_i),
	.x_stall_i      (x_stall_i),
	.jump_now_i     (jump_now_i),
	.cir_use_o      (cir_use_o),
	.flush_behind_o (flush_behind_o),
	.pc_o           (pc_o),
	.ctrl_o         (ctrl_o)
);

`default_nettype wire

// File: tb_decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_decode_stage
	import decode_pkg::*;
;

	localparam int MAX_CYCLES = 2000;

	logic              clk;
	logic              rst_n;
	fetch_t            fetch_i;
	logic              x_stall_i;
	logic              jump_now_i;
	logic [W_ADDR-1:0] jump_target_i;
	logic              jump_not_except_i;
	logic [1:0]        cir_use_o;
	logic              flush_behind_o;
	logic [W_ADDR-1:0] pc_o;
	d_ctrl_t           ctrl_o;

	// model state and scratch values
	logic [W_ADDR-1:0] pc_m;
	logic              lock_m;
	logic              m_stall;
	logic              m_assert;
	logic              m_active;
	logic              m_release;
	d_ctrl_t           exp_ctrl;
	logic              c_stall;
	logic              c_assert;
	int                cycles;
	int                seed;
	int                i;
	int                n;
	logic [31:0]       r;
	logic [31:0]       tgt;

	decode_stage i_decode_stage (
		.clk               (clk),
		.rst_n             (rst_n),
		.fetch_i           (fetch_i),
		.x_stall_i         (x_stall_i),
		.jump_now_i        (jump_now_i),
		.jump_target_i     (jump_target_i),
		.jump_not_except_i (jump_not_except_i),
		.cir_use_o         (cir_use_o),
		.flush_behind_o    (flush_behind_o),
		.pc_o              (pc_o),
		.ctrl_o            (ctrl_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------
	// reference model
	// ------------------------------

	function automatic aluop_e expected_aluop(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0:    return alt ? ALUOP_SUB : ALUOP_ADD;
			3'd1:    return ALUOP_SLL;
			3'd2:    return ALUOP_LT;
			3'd3:    return ALUOP_LTU;
			3'd4:    return ALUOP_XOR;
			3'd5:    return alt ? ALUOP_SRA : ALUOP_SRL;
			3'd6:    return ALUOP_OR;
			default: return ALUOP_AND;
		endcase
	endfunction

	function automatic d_ctrl_t ref_ctrl(input fetch_t f, input logic held);
		d_ctrl_t     c;
		logic [31:0] ins;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic        bad;
		logic        starved;
		logic        fault;
		ins   = f.cir;
		f3    = ins[14:12];
		f7    = ins[31:25];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u = {ins[31:12], 12'd0};
		imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

		c.rs1             = ins[19:15];
		c.rs2             = ins[24:20];
		c.rd              = ins[11:7];
		c.imm             = imm_i;
		c.alusrc_a        = ALUSRCA_RS1;
		c.alusrc_b        = ALUSRCB_RS2;
		c.aluop           = ALUOP_ADD;
		c.memop           = MEMOP_NONE;
		c.branchcond      = BCOND_NEVER;
		c.addr_offs       = '0;
		c.addr_is_regoffs = 1'b0;
		c.except          = EXCEPT_NONE;
		bad               = ins[1:0] != 2'b11;

		case (ins[6:2])
			OPC_LOAD: begin
				c.rs2             = '0;
				c.addr_offs       = imm_i;
				c.addr_is_regoffs = 1'b1;
				case (f3)
					3'd0:    c.memop = MEMOP_LB;
					3'd1:    c.memop = MEMOP_LH;
					3'd2:    c.memop = MEMOP_LW;
					3'd4:    c.memop = MEMOP_LBU;
					3'd5:    c.memop = MEMOP_LHU;
					default: bad = 1'b1;
				endcase
			end
			OPC_STORE: begin
				c.rd              = '0;
				c.aluop           = ALUOP_RS2;
				c.addr_offs       = imm_s;
				c.addr_is_regoffs = 1'b1;
				case (f3)
					3'd0:    c.memop = MEMOP_SB;
					3'd1:    c.memop = MEMOP_SH;
					3'd2:    c.memop = MEMOP_SW;
					default: bad = 1'b1;
				endcase
			end
			OPC_BRANCH: begin
				c.rd        = '0;
				c.addr_offs = imm_b;
				c.aluop     = (f3 == 3'd6 || f3 == 3'd7) ? ALUOP_LTU :
					((f3 == 3'd4 || f3 == 3'd5) ? ALUOP_LT : ALUOP_SUB);
				// beq, bge and bgeu are taken on a zero result
				c.branchcond = (f3 == 3'd0 || f3 == 3'd5 || f3 == 3'd7) ? BCOND_ZERO : BCOND_NZERO;
				bad          = bad || f3 == 3'd2 || f3 == 3'd3;
			end
			OPC_JALR: begin
				c.rs2             = '0;
				c.imm             = INSTR_BYTES;
				c.alusrc_a        = ALUSRCA_PC;
				c.alusrc_b        = ALUSRCB_IMM;
				c.branchcond      = BCOND_ALWAYS;
				c.addr_offs       = imm_i;
				c.addr_is_regoffs = 1'b1;
				bad               = bad || f3 != 3'd0;
			end
			OPC_JAL: begin
				c.rs1        = '0;
				c.rs2        = '0;
				c.imm        = INSTR_BYTES;
				c.alusrc_a   = ALUSRCA_PC;
				c.alusrc_b   = ALUSRCB_IMM;
				c.branchcond = BCOND_ALWAYS;
				c.addr_offs  = imm_j;
			end
			OPC_OP_IMM: begin
				c.rs2      = '0;
				c.alusrc_b = ALUSRCB_IMM;
				c.aluop    = expected_aluop(f3, f3 == 3'd5 && f7 == 7'h20);
				bad        = bad || (f3 == 3'd1 && f7 != 7'h00) ||
					(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
			end
			OPC_OP: begin
				c.aluop = expected_aluop(f3, f7 == 7'h20);
				bad     = bad || !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
			end
			OPC_LUI: begin
				c.rs1      = '0;
				c.rs2      = '0;
				c.imm      = imm_u;
				c.alusrc_b = ALUSRCB_IMM;
				c.aluop    = ALUOP_RS2;
			end
			OPC_AUIPC: begin
				c.rs1      = '0;
				c.rs2      = '0;
				c.imm      = imm_u;
				c.alusrc_a = ALUSRCA_PC;
				c.alusrc_b = ALUSRCB_IMM;
			end
			OPC_MISC_MEM: begin
				c.rs1 = '0;
				c.rs2 = '0;
				c.rd  = '0;
				bad   = bad || f3 != 3'd0;
			end
			default: bad = 1'b1;
		endcase

		starved = f.vld < 2'd2;
		fault   = (f.vld != 2'd0 && f.err[0]) || (f.vld == 2'd2 && f.err[1]);
		if (bad || starved || fault) begin
			c.rs1             = '0;
			c.rs2             = '0;
			c.rd              = '0;
			c.memop           = MEMOP_NONE;
			c.branchcond      = BCOND_NEVER;
			c.addr_is_regoffs = 1'b1;
			c.aluop           = ALUOP_ADD;
			if (fault)
				c.except = EXCEPT_INSTR_FAULT;
			else if (bad && !starved)
				c.except = EXCEPT_INSTR_ILLEGAL;
			else
				c.except = EXCEPT_NONE;
		end
		if (held)
			c.branchcond = BCOND_NEVER;
		return c;
	endfunction

	// expected PC and lock state move on each rising edge
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_m   = RESET_VECTOR;
			lock_m = 1'b0;
		end else begin
			m_stall   = x_stall_i || fetch_i.vld < 2'd2;
			m_assert  = jump_now_i && jump_not_except_i && m_stall;
			m_active  = (lock_m && m_stall) || m_assert;
			m_release = lock_m && !m_stall;
			if ((jump_now_i && !m_assert) || m_release)
				pc_m = jump_target_i;
			else if (!m_stall && !m_active)
				pc_m = pc_m + INSTR_BYTES;
			lock_m = m_active;
		end
	end

	// ------------------------------
	// checking
	// ------------------------------

	task automatic check_val(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Regression failed");
			$fatal(1, "stopping at the first wrong output");
		end
	endtask

	// outputs are settled by the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			exp_ctrl = ref_ctrl(fetch_i, lock_m);
			c_stall  = x_stall_i || fetch_i.vld < 2'd2;
			c_assert = jump_now_i && jump_not_except_i && c_stall;
			check_val("cir_use_o", 128'(cir_use_o), c_stall ? 128'd0 : 128'd2);
			check_val("flush_behind_o", 128'(flush_behind_o), 128'(c_assert && !lock_m));
			check_val("ctrl_o", 128'(ctrl_o), 128'(exp_ctrl));
			check_val("pc_o", 128'(pc_o), 128'(pc_m));
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Regression failed");
			$fatal(1, "the run went past %0d cycles without finishing", MAX_CYCLES);
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------

	function automatic logic [31:0] legal_instr(input logic [3:0] kind, input logic [31:0] rv);
		logic [31:0] ins;
		logic [2:0]  f3;
		ins      = rv;
		ins[1:0] = 2'b11;
		f3       = rv[14:12];
		case (kind)
			4'd0: begin
				ins[6:2] = OPC_LOAD;
				if (f3 == 3'd3 || f3 > 3'd5)
					f3 = 3'd2;
			end
			4'd1: begin
				ins[6:2] = OPC_STORE;
				if (f3 > 3'd2)
					f3 = 3'd0;
			end
			4'd2: begin
				ins[6:2] = OPC_BRANCH;
				if (f3[2:1] == 2'b01)
					f3 = 3'd1;
			end
			4'd3: begin
				ins[6:2] = OPC_JALR;
				f3       = 3'd0;
			end
			4'd4: ins[6:2] = OPC_JAL;
			4'd5: begin
				ins[6:2] = OPC_OP_IMM;
				if (f3 == 3'd1 || f3 == 3'd5)
					ins[31:25] = {1'b0, f3 == 3'd5 && rv[30], 5'b00000};
			end
			4'd6: begin
				ins[6:2]   = OPC_OP;
				ins[31:25] = {1'b0, (f3 == 3'd0 || f3 == 3'd5) && rv[30], 5'b00000};
			end
			4'd7: ins[6:2] = OPC_LUI;
			4'd8: ins[6:2] = OPC_AUIPC;
			default: begin
				ins[6:2] = OPC_MISC_MEM;
				f3       = 3'd0;
			end
		endcase
		ins[14:12] = f3;
		return ins;
	endfunction

	function automatic logic [31:0] illegal_instr(input logic [31:0] rv);
		logic [31:0] ins;
		ins      = rv;
		ins[1:0] = 2'b11;
		case (rv[2:0])
			3'd0: begin
				ins      = legal_instr(4'(rv[7:4] % 4'd10), rv);
				ins[1:0] = (rv[9:8] == 2'b11) ? 2'b01 : rv[9:8];
			end
			// custom-0, AMO, SYSTEM and OP-FP are all outside this core
			3'd1: ins[6:2] = rv[5] ? (rv[4] ? 5'b00010 : 5'b01011) : (rv[4] ? 5'b11100 : 5'b10100);
			3'd2: begin
				ins[6:2]   = OPC_LOAD;
				ins[14:12] = rv[5] ? 3'd6 : (rv[4] ? 3'd7 : 3'd3);
			end
			3'd3: begin
				ins[6:2]   = OPC_STORE;
				ins[14:12] = 3'd3 + {1'b0, rv[5:4]};
			end
			3'd4: begin
				ins[6:2]   = OPC_BRANCH;
				ins[14:12] = {2'b01, rv[4]};
			end
			3'd5: begin
				ins[6:2]   = OPC_JALR;
				ins[14:12] = {rv[14:13], 1'b1};
			end
			3'd6: begin
				ins[6:2]   = OPC_OP_IMM;
				ins[14:12] = rv[4] ? 3'd1 : 3'd5;
				ins[31]    = 1'b1;
			end
			default: begin
				ins[6:2]   = rv[6] ? OPC_OP : OPC_MISC_MEM;
				ins[31]    = 1'b1;
				ins[12]    = 1'b1;
			end
		endcase
		return ins;
	endfunction

	task automatic drive(input logic [31:0] cir, input logic [1:0] vld, input logic [1:0] err,
			input logic stall, input logic jn, input logic jne, input logic [31:0] target);
		@(posedge clk);
		fetch_i           <= {cir, vld, err};
		x_stall_i         <= stall;
		jump_now_i        <= jn;
		jump_not_except_i <= jne;
		jump_target_i     <= target;
	endtask

	initial begin
		rst_n             = 1'b0;
		fetch_i           = '0;
		x_stall_i         = 1'b0;
		jump_now_i        = 1'b0;
		jump_target_i     = '0;
		jump_not_except_i = 1'b0;
		cycles            = 0;
		seed              = 50209;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// empty fetch buffer right after reset
		@(negedge clk);
		check_val("pc_o", 128'(pc_o), 128'(RESET_VECTOR));
		check_val("flush_behind_o", 128'(flush_behind_o), 128'd0);
		check_val("ctrl_o.except", 128'(ctrl_o.except), 128'(EXCEPT_NONE));
		repeat (10) drive($random(seed), 2'd0, 2'b00, 1'b0, 1'b0, 1'b0, 32'd0);

		for (i = 0; i < 350; i++) begin
			r = $random(seed);
			drive(legal_instr(4'(r[7:0] % 8'd10), $random(seed)), 2'd2, 2'b00, 1'b0, 1'b0,
				1'b0, 32'd0);
		end
		for (i = 0; i < 200; i++)
			drive(illegal_instr($random(seed)), 2'd2, 2'b00, 1'b0, 1'b0, 1'b0, 32'd0);

		// bus errors, partly on top of illegal encodings
		for (i = 0; i < 100; i++) begin
			r = $random(seed);
			drive(r[7] ? illegal_instr($random(seed)) : legal_instr(4'(r[11:8] % 4'd10), r),
				r[4] ? 2'd2 : 2'd1, (r[6:5] == 2'b00) ? 2'b01 : r[6:5], 1'b0, 1'b0, 1'b0, 32'd0);
		end

		// back-pressure and starvation
		for (i = 0; i < 200; i++) begin
			r = $random(seed);
			drive(r[2] ? illegal_instr($random(seed)) : legal_instr(4'(r[7:4] % 4'd10), r),
				r[9:8] % 2'd3, 2'b00, r[0], 1'b0, 1'b0, 32'd0);
		end

		for (i = 0; i < 40; i++) begin
			r = $random(seed);
			drive(legal_instr(4'(r[7:4] % 4'd10), r), 2'd2, 2'b00, 1'b0, 1'b1, r[1],
				{r[31:2], 2'b00});
			drive(legal_instr(4'(r[11:8] % 4'd10), r), 2'd2, 2'b00, 1'b0, 1'b0, 1'b0, 32'd0);
		end

		// jumps that arrive while decode is stalled
		for (i = 0; i < 20; i++) begin
			r   = $random(seed);
			tgt = {r[31:2], 2'b00};
			n   = 1 + int'(r[5:4]);
			drive(legal_instr(4'd4, r), r[0] ? 2'd2 : 2'd1, 2'b00, r[0], 1'b0, 1'b0, tgt);
			drive(legal_instr(4'd4, r), r[0] ? 2'd2 : 2'd1, 2'b00, r[0], 1'b1, 1'b1, tgt);
			repeat (n) drive(legal_instr(4'd4, r), r[0] ? 2'd2 : 2'd1, 2'b00, r[0], 1'b0,
				1'b0, tgt);
			drive(legal_instr(4'd4, r), 2'd2, 2'b00, 1'b0, 1'b0, 1'b0, tgt);
			drive(legal_instr(4'd7, r), 2'd2, 2'b00, 1'b0, 1'b0, 1'b0, tgt);
		end

		// everything at once
		for (i = 0; i < 150; i++) begin
			r = $random(seed);
			drive(r[24] ? illegal_instr($random(seed)) : legal_instr(4'(r[7:4] % 4'd10), r),
				(r[23:22] == 2'b00) ? r[9:8] % 2'd3 : 2'd2,
				(r[19:16] == 4'd0) ? r[21:20] : 2'b00,
				r[14] && r[15], r[12:10] == 3'd0, r[13], {r[31:26], r[25:2], 2'b00});
		end

		drive(32'h0000_0013, 2'd0, 2'b00, 1'b0, 1'b0, 1'b0, 32'd0);
		@(negedge clk);
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: decode_stage.f
decode_pkg.sv
instr_decoder.sv
decode_gate.sv
cir_ctrl.sv
pc_reg.sv
decode_stage.sv
decode_stage_chk.sv
tb_decode_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench; the exit status follows the simulation
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert --top-module tb_decode_stage \
		-f decode_stage.f -o sim_decode_stage &&
	./obj_dir/sim_decode_stage ||
	{ echo "decode stage simulation did not pass"; exit 1; }
